//--- hdl/datapath_settings.svh
`ifndef DATAPATH_SETTINGS_SVH
`define DATAPATH_SETTINGS_SVH

// Bus and register width
`define DP_WIDTH    8
`define DP_CTRL_W   45

// Reset and precharge values
`define DP_RST_S    8'hFF
`define DP_RST_P    8'h20
`define DP_BUS_IDLE 8'hFF

// Bus drive enables
`define CTRL_DL_DB     0
`define CTRL_DL_ADL    1
`define CTRL_DL_ADH    2
`define CTRL_PCL_DB    3
`define CTRL_PCL_ADL   4
`define CTRL_PCH_DB    5
`define CTRL_PCH_ADH   6
`define CTRL_X_SB      7
`define CTRL_Y_SB      8
`define CTRL_AC_SB     9
`define CTRL_AC_DB     10
`define CTRL_S_SB      11
`define CTRL_S_ADL     12
`define CTRL_ADD_SB7   13
`define CTRL_ADD_SB06  14
`define CTRL_ADD_ADL   15
`define CTRL_P_DB      16
`define CTRL_0_ADL0    17
`define CTRL_0_ADL1    18
`define CTRL_0_ADL2    19
`define CTRL_0_ADH0    20
`define CTRL_0_ADH17   21
`define CTRL_SB_ADH    22
`define CTRL_SB_DB     23

// Register load strobes
`define CTRL_DL_LOAD   24
`define CTRL_SB_X      25
`define CTRL_SB_Y      26
`define CTRL_SB_AC     27
`define CTRL_SB_S      28
`define CTRL_DB_P      29
`define CTRL_ADL_PCL   30
`define CTRL_ADH_PCH   31
`define CTRL_PC_INC    32

// Adder input selects and operations
`define CTRL_SB_A      33
`define CTRL_0_A       34
`define CTRL_DB_B      35
`define CTRL_NDB_B     36
`define CTRL_ADL_B     37
`define CTRL_ALU_SUM   38
`define CTRL_ALU_AND   39
`define CTRL_ALU_OR    40
`define CTRL_ALU_EOR   41
`define CTRL_ALU_SR    42
`define CTRL_CARRY_IN  43
`define CTRL_ADD_LOAD  44

`endif

//--- hdl/datapath_pkg.sv
`default_nettype none
`include "datapath_settings.svh"

package datapath_pkg;

    // Status register, seen either as a byte or as named flags
    typedef union packed {
        logic [`DP_WIDTH-1:0] raw;
        struct packed {
            logic n;
            logic v;
            logic one;
            logic b;
            logic d;
            logic i;
            logic z;
            logic c;
        } flag;
    } p_word_t;

endpackage

`default_nettype wire

//--- hdl/register_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_settings.svh"

module register_bank (
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    input  wire [`DP_WIDTH-1:0]   i_data,
    input  wire [`DP_WIDTH-1:0]   i_bus_db,
    input  wire [`DP_WIDTH-1:0]   i_bus_sb,
    input  wire [`DP_WIDTH-1:0]   i_bus_adl,
    input  wire [`DP_WIDTH-1:0]   i_bus_adh,
    input  wire                   i_dl_load,
    input  wire                   i_sb_x,
    input  wire                   i_sb_y,
    input  wire                   i_sb_ac,
    input  wire                   i_sb_s,
    input  wire                   i_db_p,
    input  wire                   i_adl_pcl,
    input  wire                   i_adh_pch,
    input  wire                   i_pc_inc,
    input  wire                   i_flag_we,
    input  wire datapath_pkg::p_word_t i_flags,
    output logic [`DP_WIDTH-1:0]  o_dl,
    output logic [`DP_WIDTH-1:0]  o_x,
    output logic [`DP_WIDTH-1:0]  o_y,
    output logic [`DP_WIDTH-1:0]  o_ac,
    output logic [`DP_WIDTH-1:0]  o_s,
    output datapath_pkg::p_word_t o_p,
    output logic [`DP_WIDTH-1:0]  o_pcl,
    output logic [`DP_WIDTH-1:0]  o_pch
);

    logic pcl_carry;

    // PCL wraps from FF into PCH
    assign pcl_carry = i_pc_inc && (o_pcl == {`DP_WIDTH{1'b1}});

    // Input data latch takes the memory byte
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            o_dl <= '0;
        else if (i_dl_load)
            o_dl <= i_data;
    end

    // Index, accumulator and stack all load from SB
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_x  <= '0;
            o_y  <= '0;
            o_ac <= '0;
            o_s  <= `DP_RST_S;
        end
        else
        begin
            if (i_sb_x)
                o_x <= i_bus_sb;
            if (i_sb_y)
                o_y <= i_bus_sb;
            if (i_sb_ac)
                o_ac <= i_bus_sb;
            if (i_sb_s)
                o_s <= i_bus_sb;
        end
    end

    // Program counter pair where a bus load beats the increment per byte
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_pcl <= '0;
            o_pch <= '0;
        end
        else
        begin
            if (i_adl_pcl)
                o_pcl <= i_bus_adl;
            else if (i_pc_inc)
                o_pcl <= o_pcl + 1'b1;
            if (i_adh_pch)
                o_pch <= i_bus_adh;
            else if (pcl_carry)
                o_pch <= o_pch + 1'b1;
        end
    end

    // Status register
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            o_p <= `DP_RST_P;
        else if (i_db_p)
        begin
            o_p.raw      <= i_bus_db;
            // bit 5 reads back as one on the real part too
            o_p.flag.one <= 1'b1;
        end
        else if (i_flag_we)
        begin
            o_p.flag.n <= i_flags.flag.n;
            o_p.flag.v <= i_flags.flag.v;
            o_p.flag.z <= i_flags.flag.z;
            o_p.flag.c <= i_flags.flag.c;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bus_routing.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_settings.svh"

module bus_routing (
    // Clock and reset are unused by the combinational network
    input  wire                  i_clk,
    input  wire                  i_rst_n,
    input  wire [`DP_WIDTH-1:0]  i_dl,
    input  wire                  i_dl_db,
    input  wire                  i_dl_adl,
    input  wire                  i_dl_adh,
    input  wire [`DP_WIDTH-1:0]  i_pcl,
    input  wire                  i_pcl_adl,
    input  wire                  i_pcl_db,
    input  wire [`DP_WIDTH-1:0]  i_pch,
    input  wire                  i_pch_adh,
    input  wire                  i_pch_db,
    input  wire [`DP_WIDTH-1:0]  i_x,
    input  wire                  i_x_sb,
    input  wire [`DP_WIDTH-1:0]  i_y,
    input  wire                  i_y_sb,
    input  wire [`DP_WIDTH-1:0]  i_ac,
    input  wire                  i_ac_sb,
    input  wire                  i_ac_db,
    input  wire [`DP_WIDTH-1:0]  i_s,
    input  wire                  i_s_sb,
    input  wire                  i_s_adl,
    input  wire [`DP_WIDTH-1:0]  i_add,
    input  wire                  i_add_sb_7,
    input  wire                  i_add_sb_0_6,
    input  wire                  i_add_adl,
    input  wire [`DP_WIDTH-1:0]  i_p,
    input  wire                  i_p_db,
    // Open-drain pulldowns
    input  wire                  i_0_adl0,
    input  wire                  i_0_adl1,
    input  wire                  i_0_adl2,
    input  wire                  i_0_adh0,
    input  wire                  i_0_adh1_7,
    // Pass transistors between buses
    input  wire                  i_sb_adh,
    input  wire                  i_sb_db,
    output logic [`DP_WIDTH-1:0] o_bus_db,
    output logic [`DP_WIDTH-1:0] o_bus_sb,
    output logic [`DP_WIDTH-1:0] o_bus_adl,
    output logic [`DP_WIDTH-1:0] o_bus_adh
);

    // SB resolves first since DB and ADH can take it through the pass gates
    always_comb
    begin
        o_bus_sb = `DP_BUS_IDLE;
        if (i_x_sb)
            o_bus_sb = i_x;
        if (i_y_sb)
            o_bus_sb = i_y;
        if (i_ac_sb)
            o_bus_sb = i_ac;
        if (i_s_sb)
            o_bus_sb = i_s;
        // ADD drives the sign bit and the low seven separately
        if (i_add_sb_7)
            o_bus_sb[`DP_WIDTH-1] = i_add[`DP_WIDTH-1];
        if (i_add_sb_0_6)
            o_bus_sb[`DP_WIDTH-2:0] = i_add[`DP_WIDTH-2:0];
    end

    always_comb
    begin
        o_bus_db = `DP_BUS_IDLE;
        if (i_dl_db)
            o_bus_db = i_dl;
        if (i_pcl_db)
            o_bus_db = i_pcl;
        if (i_pch_db)
            o_bus_db = i_pch;
        if (i_ac_db)
            o_bus_db = i_ac;
        if (i_p_db)
            o_bus_db = i_p;
        if (i_sb_db)
            o_bus_db = o_bus_sb;
    end

    always_comb
    begin
        o_bus_adl = `DP_BUS_IDLE;
        if (i_dl_adl)
            o_bus_adl = i_dl;
        if (i_pcl_adl)
            o_bus_adl = i_pcl;
        if (i_s_adl)
            o_bus_adl = i_s;
        if (i_add_adl)
            o_bus_adl = i_add;
        // Pulldowns win over any driver
        if (i_0_adl0)
            o_bus_adl[0] = 1'b0;
        if (i_0_adl1)
            o_bus_adl[1] = 1'b0;
        if (i_0_adl2)
            o_bus_adl[2] = 1'b0;
    end

    always_comb
    begin
        o_bus_adh = `DP_BUS_IDLE;
        if (i_dl_adh)
            o_bus_adh = i_dl;
        if (i_pch_adh)
            o_bus_adh = i_pch;
        if (i_sb_adh)
            o_bus_adh = o_bus_sb;
        if (i_0_adh0)
            o_bus_adh[0] = 1'b0;
        if (i_0_adh1_7)
            o_bus_adh[`DP_WIDTH-1:1] = '0;
    end

endmodule

`default_nettype wire

//--- hdl/adder_hold.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_settings.svh"

module adder_hold (
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    input  wire [`DP_WIDTH-1:0]   i_bus_sb,
    input  wire [`DP_WIDTH-1:0]   i_bus_db,
    input  wire [`DP_WIDTH-1:0]   i_bus_adl,
    input  wire                   i_sb_a,
    input  wire                   i_zero_a,
    input  wire                   i_db_b,
    input  wire                   i_ndb_b,
    input  wire                   i_adl_b,
    input  wire                   i_op_sum,
    input  wire                   i_op_and,
    input  wire                   i_op_or,
    input  wire                   i_op_eor,
    input  wire                   i_op_sr,
    input  wire                   i_carry_in,
    input  wire                   i_add_load,
    input  wire datapath_pkg::p_word_t i_p,
    output logic [`DP_WIDTH-1:0]  o_add,
    output datapath_pkg::p_word_t o_flags,
    output logic                  o_flag_we
);

    logic [`DP_WIDTH-1:0] a_in;
    logic [`DP_WIDTH-1:0] b_in;
    logic                 cin;
    logic [`DP_WIDTH:0]   sum_full;
    logic [`DP_WIDTH-1:0] result;
    logic                 carry_out;
    logic                 overflow;

    // Unselected inputs float high like a precharged bus
    always_comb
    begin
        a_in = `DP_BUS_IDLE;
        if (i_sb_a)
            a_in = i_bus_sb;
        if (i_zero_a)
            a_in = '0;
    end

    always_comb
    begin
        b_in = `DP_BUS_IDLE;
        if (i_db_b)
            b_in = i_bus_db;
        if (i_ndb_b)
            b_in = ~i_bus_db;
        if (i_adl_b)
            b_in = i_bus_adl;
    end

    assign cin      = i_carry_in & i_p.flag.c;
    assign sum_full = {1'b0, a_in} + {1'b0, b_in} + {{`DP_WIDTH{1'b0}}, cin};

    // Operation outputs are wire-ORed together
    assign result = ({`DP_WIDTH{i_op_sum}} & sum_full[`DP_WIDTH-1:0])
                  | ({`DP_WIDTH{i_op_and}} & (a_in & b_in))
                  | ({`DP_WIDTH{i_op_or}}  & (a_in | b_in))
                  | ({`DP_WIDTH{i_op_eor}} & (a_in ^ b_in))
                  | ({`DP_WIDTH{i_op_sr}}  & (a_in >> 1));

    // SR shifts bit 0 out into carry
    assign carry_out = (i_op_sum & sum_full[`DP_WIDTH]) | (i_op_sr & a_in[0]);
    assign overflow  = i_op_sum & (a_in[`DP_WIDTH-1] == b_in[`DP_WIDTH-1])
                     & (sum_full[`DP_WIDTH-1] != a_in[`DP_WIDTH-1]);

    always_comb
    begin
        o_flags        = i_p;
        o_flags.flag.n = result[`DP_WIDTH-1];
        o_flags.flag.v = overflow;
        o_flags.flag.z = (result == '0);
        o_flags.flag.c = carry_out;
    end

    // Flags go to P on the same edge that captures ADD
    assign o_flag_we = i_add_load;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            o_add <= '0;
        else if (i_add_load)
            o_add <= result;
    end

endmodule

`default_nettype wire

//--- hdl/datapath_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_settings.svh"

module datapath_top (
    input  wire                  i_clk,
    input  wire                  i_rst_n,
    input  wire [`DP_CTRL_W-1:0] i_ctrl,
    input  wire [`DP_WIDTH-1:0]  i_data,
    output logic [`DP_WIDTH-1:0] o_bus_db,
    output logic [`DP_WIDTH-1:0] o_bus_sb,
    output logic [`DP_WIDTH-1:0] o_bus_adl,
    output logic [`DP_WIDTH-1:0] o_bus_adh
);

    logic [`DP_WIDTH-1:0]  dl;
    logic [`DP_WIDTH-1:0]  x;
    logic [`DP_WIDTH-1:0]  y;
    logic [`DP_WIDTH-1:0]  ac;
    logic [`DP_WIDTH-1:0]  s;
    logic [`DP_WIDTH-1:0]  pcl;
    logic [`DP_WIDTH-1:0]  pch;
    logic [`DP_WIDTH-1:0]  add;
    datapath_pkg::p_word_t p_reg;
    datapath_pkg::p_word_t alu_flags;
    logic                  flag_we;

    register_bank u_register_bank (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_data    (i_data),
        .i_bus_db  (o_bus_db),
        .i_bus_sb  (o_bus_sb),
        .i_bus_adl (o_bus_adl),
        .i_bus_adh (o_bus_adh),
        .i_dl_load (i_ctrl[`CTRL_DL_LOAD]),
        .i_sb_x    (i_ctrl[`CTRL_SB_X]),
        .i_sb_y    (i_ctrl[`CTRL_SB_Y]),
        .i_sb_ac   (i_ctrl[`CTRL_SB_AC]),
        .i_sb_s    (i_ctrl[`CTRL_SB_S]),
        .i_db_p    (i_ctrl[`CTRL_DB_P]),
        .i_adl_pcl (i_ctrl[`CTRL_ADL_PCL]),
        .i_adh_pch (i_ctrl[`CTRL_ADH_PCH]),
        .i_pc_inc  (i_ctrl[`CTRL_PC_INC]),
        .i_flag_we (flag_we),
        .i_flags   (alu_flags),
        .o_dl      (dl),
        .o_x       (x),
        .o_y       (y),
        .o_ac      (ac),
        .o_s       (s),
        .o_p       (p_reg),
        .o_pcl     (pcl),
        .o_pch     (pch)
    );

    // Buses leave the top straight from the network and loop back to the blocks
    bus_routing u_bus_routing (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_dl         (dl),
        .i_dl_db      (i_ctrl[`CTRL_DL_DB]),
        .i_dl_adl     (i_ctrl[`CTRL_DL_ADL]),
        .i_dl_adh     (i_ctrl[`CTRL_DL_ADH]),
        .i_pcl        (pcl),
        .i_pcl_adl    (i_ctrl[`CTRL_PCL_ADL]),
        .i_pcl_db     (i_ctrl[`CTRL_PCL_DB]),
        .i_pch        (pch),
        .i_pch_adh    (i_ctrl[`CTRL_PCH_ADH]),
        .i_pch_db     (i_ctrl[`CTRL_PCH_DB]),
        .i_x          (x),
        .i_x_sb       (i_ctrl[`CTRL_X_SB]),
        .i_y          (y),
        .i_y_sb       (i_ctrl[`CTRL_Y_SB]),
        .i_ac         (ac),
        .i_ac_sb      (i_ctrl[`CTRL_AC_SB]),
        .i_ac_db      (i_ctrl[`CTRL_AC_DB]),
        .i_s          (s),
        .i_s_sb       (i_ctrl[`CTRL_S_SB]),
        .i_s_adl      (i_ctrl[`CTRL_S_ADL]),
        .i_add        (add),
        .i_add_sb_7   (i_ctrl[`CTRL_ADD_SB7]),
        .i_add_sb_0_6 (i_ctrl[`CTRL_ADD_SB06]),
        .i_add_adl    (i_ctrl[`CTRL_ADD_ADL]),
        .i_p          (p_reg.raw),
        .i_p_db       (i_ctrl[`CTRL_P_DB]),
        .i_0_adl0     (i_ctrl[`CTRL_0_ADL0]),
        .i_0_adl1     (i_ctrl[`CTRL_0_ADL1]),
        .i_0_adl2     (i_ctrl[`CTRL_0_ADL2]),
        .i_0_adh0     (i_ctrl[`CTRL_0_ADH0]),
        .i_0_adh1_7   (i_ctrl[`CTRL_0_ADH17]),
        .i_sb_adh     (i_ctrl[`CTRL_SB_ADH]),
        .i_sb_db      (i_ctrl[`CTRL_SB_DB]),
        .o_bus_db     (o_bus_db),
        .o_bus_sb     (o_bus_sb),
        .o_bus_adl    (o_bus_adl),
        .o_bus_adh    (o_bus_adh)
    );

    adder_hold u_adder_hold (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_bus_sb   (o_bus_sb),
        .i_bus_db   (o_bus_db),
        .i_bus_adl  (o_bus_adl),
        .i_sb_a     (i_ctrl[`CTRL_SB_A]),
        .i_zero_a   (i_ctrl[`CTRL_0_A]),
        .i_db_b     (i_ctrl[`CTRL_DB_B]),
        .i_ndb_b    (i_ctrl[`CTRL_NDB_B]),
        .i_adl_b    (i_ctrl[`CTRL_ADL_B]),
        .i_op_sum   (i_ctrl[`CTRL_ALU_SUM]),
        .i_op_and   (i_ctrl[`CTRL_ALU_AND]),
        .i_op_or    (i_ctrl[`CTRL_ALU_OR]),
        .i_op_eor   (i_ctrl[`CTRL_ALU_EOR]),
        .i_op_sr    (i_ctrl[`CTRL_ALU_SR]),
        .i_carry_in (i_ctrl[`CTRL_CARRY_IN]),
        .i_add_load (i_ctrl[`CTRL_ADD_LOAD]),
        .i_p        (p_reg),
        .o_add      (add),
        .o_flags    (alu_flags),
        .o_flag_we  (flag_we)
    );

endmodule

`default_nettype wire

//--- tb/datapath_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_settings.svh"

module datapath_checker (
    input  wire                 i_clk,
    input  wire                 i_valid,
    input  wire                 i_flush,
    input  wire [7:0]           i_test_id,
    input  wire [`DP_WIDTH-1:0] i_exp_db,
    input  wire [`DP_WIDTH-1:0] i_exp_sb,
    input  wire [`DP_WIDTH-1:0] i_exp_adl,
    input  wire [`DP_WIDTH-1:0] i_exp_adh,
    input  wire [`DP_WIDTH-1:0] i_bus_db,
    input  wire [`DP_WIDTH-1:0] i_bus_sb,
    input  wire [`DP_WIDTH-1:0] i_bus_adl,
    input  wire [`DP_WIDTH-1:0] i_bus_adh,
    output int                  o_checks,
    output int                  o_errors,
    output int                  o_tests
);

    logic [7:0] cur_id    = '0;
    logic       test_open = 1'b0;
    int         test_errs = 0;
    int         test_chks = 0;
    int         checks    = 0;
    int         errors    = 0;
    int         tests     = 0;

    assign o_checks = checks;
    assign o_errors = errors;
    assign o_tests  = tests;

    task automatic compare_bus(input string name, input logic [`DP_WIDTH-1:0] exp_val,
                               input logic [`DP_WIDTH-1:0] act_val);
        checks    = checks + 1;
        test_chks = test_chks + 1;
        if (act_val !== exp_val)
        begin
            $display("CHECK FAILED at %0t: %s expected %02h, got %02h",
                     $time, name, exp_val, act_val);
            errors    = errors + 1;
            test_errs = test_errs + 1;
        end
    endtask

    task automatic close_test();
        if (test_errs == 0)
            $display("Test %0d: pass, %0d checks", cur_id, test_chks);
        else
            $display("Test %0d: failed with %0d mismatches", cur_id, test_errs);
        tests     = tests + 1;
        test_errs = 0;
        test_chks = 0;
        test_open = 1'b0;
    endtask

    // Buses still hold this cycle's values before the registers update
    always @(posedge i_clk)
    begin
        if (i_valid)
        begin
            if (test_open && i_test_id != cur_id)
                close_test();
            cur_id    = i_test_id;
            test_open = 1'b1;
            compare_bus("DB", i_exp_db, i_bus_db);
            compare_bus("SB", i_exp_sb, i_bus_sb);
            compare_bus("ADL", i_exp_adl, i_bus_adl);
            compare_bus("ADH", i_exp_adh, i_bus_adh);
        end
        if (i_flush && test_open)
            close_test();
    end

endmodule

`default_nettype wire

//--- tb/tb_datapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_settings.svh"

module tb_datapath;

    localparam int VEC_COUNT    = 24;
    // id, control word, memory byte, DB, SB, ADL, ADH
    localparam int FIELDS       = 7;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + VEC_COUNT + 20;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [`DP_CTRL_W-1:0] ctrl;
    logic [`DP_WIDTH-1:0]  data;
    logic [`DP_WIDTH-1:0]  bus_db;
    logic [`DP_WIDTH-1:0]  bus_sb;
    logic [`DP_WIDTH-1:0]  bus_adl;
    logic [`DP_WIDTH-1:0]  bus_adh;
    logic                  vec_valid;
    logic                  flush;
    logic [7:0]            test_id;
    logic [`DP_WIDTH-1:0]  exp_db;
    logic [`DP_WIDTH-1:0]  exp_sb;
    logic [`DP_WIDTH-1:0]  exp_adl;
    logic [`DP_WIDTH-1:0]  exp_adh;
    logic [47:0]           golden [0:VEC_COUNT*FIELDS-1];
    logic                  load_failed;
    int                    cycle_count = 0;
    int                    checks;
    int                    errors;
    int                    tests;

    always #2 clk = ~clk;

    datapath_top u_datapath_top (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_ctrl    (ctrl),
        .i_data    (data),
        .o_bus_db  (bus_db),
        .o_bus_sb  (bus_sb),
        .o_bus_adl (bus_adl),
        .o_bus_adh (bus_adh)
    );

    datapath_checker u_checker (
        .i_clk     (clk),
        .i_valid   (vec_valid),
        .i_flush   (flush),
        .i_test_id (test_id),
        .i_exp_db  (exp_db),
        .i_exp_sb  (exp_sb),
        .i_exp_adl (exp_adl),
        .i_exp_adh (exp_adh),
        .i_bus_db  (bus_db),
        .i_bus_sb  (bus_sb),
        .i_bus_adl (bus_adl),
        .i_bus_adh (bus_adh),
        .o_checks  (checks),
        .o_errors  (errors),
        .o_tests   (tests)
    );

    // Guard against a stuck run
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        rst_n       = 1'b0;
        ctrl        = '0;
        data        = '0;
        vec_valid   = 1'b0;
        flush       = 1'b0;
        test_id     = '0;
        exp_db      = '0;
        exp_sb      = '0;
        exp_adl     = '0;
        exp_adh     = '0;
        load_failed = 1'b0;
        // Marker in the top bits that no real entry uses shows rows left unfilled
        for (int k = 0; k < VEC_COUNT*FIELDS; k++)
            golden[k] = {3'b111, 45'(k)};
        $readmemh("tb/datapath_golden.mem", golden);
        if (golden[0][47:45] != 3'b000 || golden[VEC_COUNT*FIELDS-1][47:45] != 3'b000)
        begin
            $display("Golden vector file tb/datapath_golden.mem could not be read");
            load_failed = 1'b1;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        // New vector on every falling edge, checked on the next rising edge
        for (int idx = 0; idx < VEC_COUNT && !load_failed; idx++)
        begin
            test_id   = golden[idx*FIELDS][7:0];
            ctrl      = golden[idx*FIELDS+1][`DP_CTRL_W-1:0];
            data      = golden[idx*FIELDS+2][`DP_WIDTH-1:0];
            exp_db    = golden[idx*FIELDS+3][`DP_WIDTH-1:0];
            exp_sb    = golden[idx*FIELDS+4][`DP_WIDTH-1:0];
            exp_adl   = golden[idx*FIELDS+5][`DP_WIDTH-1:0];
            exp_adh   = golden[idx*FIELDS+6][`DP_WIDTH-1:0];
            vec_valid = 1'b1;
            @(negedge clk);
        end
        vec_valid = 1'b0;
        ctrl      = '0;
        flush     = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        $display("Totals: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (load_failed || errors != 0)
            $display("Done: errors found");
        else
            $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/datapath_golden.mem
// Columns: test id, control word (45 bits), memory byte,
// then expected DB, SB, ADL, ADH for that cycle
// 1: idle buses, S on SB, P on DB
01 000000000000 00 FF FF FF FF
01 000000000800 00 FF FF FF FF
01 000000010000 00 20 FF FF FF
// 2: DB priority and SB pass onto DB
02 000009000800 5A FF FF FF FF
02 000000000001 00 5A FF FF FF
02 000000010401 00 20 FF FF FF
02 000000810481 00 00 00 FF FF
// 3: ADD split halves on SB
03 111400000001 00 5A FF FF FF
03 000000002080 00 FF 80 FF FF
03 000000014080 00 A0 25 FF FF
// 4: open-drain zeros, vector addresses
04 0000000A0000 00 FF FF FA FF
04 000000060000 00 FF FF FC FF
04 000000020000 00 FF FF FE FF
04 0000003E0002 00 FF FF 58 00
// 5: DL through adder into AC, then AC plus DL
05 000001000000 64 FF FF FF FF
05 104C00000001 00 64 FF FF FF
05 000008006000 00 FF 64 FF FF
05 104A00000201 00 64 64 FF FF
05 000000016000 00 E0 C8 FF FF
// 6: PC load and increment with carry
06 000001000000 FF FF FF FF FF
06 000041000002 12 FF FF FF FF
06 000080000004 00 FF FF FF 12
06 000100000048 00 FF FF FF 12
06 000000000048 00 00 FF FF 13

//--- filelist.f
+incdir+hdl
hdl/datapath_pkg.sv
hdl/register_bank.sv
hdl/bus_routing.sv
hdl/adder_hold.sv
hdl/datapath_top.sv
tb/datapath_checker.sv
tb/tb_datapath.sv

//--- Makefile
TOP := tb_datapath

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f filelist.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir
